//--- common/aluPkg.sv
//////////////////////////////
// Opcode and shift kind types shared by the ALU RTL and its checker
// Import where the types are needed
//////////////////////////////
package aluPkg;

   //////////////////////////////
   // ALU operation codes
   //////////////////////////////
   typedef enum logic [3:0] {
      opEq   = 4'b0000,   // Equality compare
      opLt   = 4'b0001,   // Signed less than
      opLtu  = 4'b0010,   // Unsigned less than
      opGt   = 4'b0011,   // Signed greater than
      opGtu  = 4'b0100,   // Unsigned greater than
      opAdd  = 4'b0101,
      opAddc = 4'b0110,   // Add with carry-in
      opSub  = 4'b0111,
      opSll  = 4'b1000,
      opSrl  = 4'b1001,
      opSra  = 4'b1010,
      opOr   = 4'b1011,
      opXor  = 4'b1100,
      opAnd  = 4'b1101
   } aluOp_e;
   // Codes 4'b1110 and 4'b1111 are not defined
   // and give a zero result with cleared flags

   //////////////////////////////
   // Shift kinds
   //////////////////////////////
   // Match the low two bits of opSll, opSrl and opSra
   typedef enum logic [1:0] {
      shSll = 2'b00,   // Zero fill from the right
      shSrl = 2'b01,   // Zero fill from the left
      shSra = 2'b10    // Sign fill from the left
   } shiftOp_e;

   // Shift kind carried in the opcode low bits
   function automatic shiftOp_e shiftKindOf(input aluOp_e op);
      shiftOp_e kind;
      kind = shiftOp_e'(op[1:0]);
      return kind;
   endfunction

endpackage

//--- alu/carrySkipAdder.sv
//////////////////////////////
// Carry-skip adder made of ripple blocks with a bypass per block
// dataW must be a multiple of skipBlock
//////////////////////////////
`timescale 1ns/100ps

module carrySkipAdder #(
   parameter int dataW     = 32,
   parameter int skipBlock = 4
) (
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  logic             carryIn,
   output logic [dataW-1:0] sum,
   output logic             carryOut
);

   localparam int numBlocks = dataW / skipBlock;

   logic [dataW-1:0]   prop;       // Bit propagate
   logic [dataW-1:0]   gen;        // Bit generate
   logic [numBlocks:0] blkCarry;   // Carry between blocks

   assign prop        = a ^ b;
   assign gen         = a & b;
   assign blkCarry[0] = carryIn;

   //////////////////////////////
   // Ripple blocks
   //////////////////////////////
   genvar blk;
   genvar bitIdx;
   generate
      for (blk = 0; blk < numBlocks; blk++) begin : gBlock
         logic [skipBlock:0] rip;      // Ripple carry inside the block
         logic               blkProp;  // Every bit of the block propagates

         assign rip[0] = blkCarry[blk];

         for (bitIdx = 0; bitIdx < skipBlock; bitIdx++) begin : gBit
            assign rip[bitIdx+1] = gen[blk*skipBlock+bitIdx]
                                 | (prop[blk*skipBlock+bitIdx] & rip[bitIdx]);
         end

         assign sum[blk*skipBlock +: skipBlock] =
            prop[blk*skipBlock +: skipBlock] ^ rip[skipBlock-1:0];

         assign blkProp = &prop[blk*skipBlock +: skipBlock];

         // Skip path
         // Incoming carry goes straight through when the whole block propagates
         assign blkCarry[blk+1] = blkProp ? blkCarry[blk] : rip[skipBlock];
      end
   endgenerate

   assign carryOut = blkCarry[numBlocks];

endmodule

//--- alu/barrelShifter.sv
//////////////////////////////
// Logarithmic barrel shifter for sll, srl and sra
//////////////////////////////
`timescale 1ns/100ps

module barrelShifter #(
   parameter int dataW = 32
) (
   input  logic [dataW-1:0]         data,
   input  logic [$clog2(dataW)-1:0] shamt,
   input  aluPkg::shiftOp_e         shiftKind,
   output logic [dataW-1:0]         shifted
);
   import aluPkg::*;

   localparam int numStages = $clog2(dataW);

   logic             fillBit;    // Bit shifted in on right shifts
   logic             leftShift;
   logic [dataW-1:0] stage [0:numStages];

   assign leftShift = (shiftKind == shSll);
   assign fillBit   = (shiftKind == shSra) ? data[dataW-1] : 1'b0;
   assign stage[0]  = data;

   //////////////////////////////
   // Shift stages of 1, 2, 4 and so on
   //////////////////////////////
   genvar s;
   generate
      for (s = 0; s < numStages; s++) begin : gStage
         localparam int step = 1 << s;

         logic [dataW-1:0] leftVal;
         logic [dataW-1:0] rightVal;

         assign leftVal  = {stage[s][dataW-1-step:0], {step{1'b0}}};
         assign rightVal = {{step{fillBit}}, stage[s][dataW-1:step]};

         // Stage passes through when its shamt bit is clear
         assign stage[s+1] = !shamt[s] ? stage[s]
                           : leftShift ? leftVal
                           : rightVal;
      end
   endgenerate

   assign shifted = stage[numStages];

endmodule

//--- alu/aluCore.sv
//////////////////////////////
// Combinational ALU that decodes the opcode into a result and ZVNC flags
//////////////////////////////
`timescale 1ns/100ps

module aluCore #(
   parameter int dataW     = 32,
   parameter int skipBlock = 4
) (
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  aluPkg::aluOp_e   op,
   input  logic             cin,
   output logic [dataW-1:0] y,
   output logic             zero,
   output logic             overflow,
   output logic             negative,
   output logic             carry
);
   import aluPkg::*;

   localparam int shW = $clog2(dataW);

   // Adder side
   logic [dataW-1:0] addB;       // opB or its complement
   logic             addCin;
   logic [dataW-1:0] sum;
   logic             addCout;
   logic             addOvf;

   // Shifter side
   shiftOp_e         shiftKind;
   logic [shW-1:0]   shamt;
   logic [dataW-1:0] shifted;

   logic             trueZero;   // Z is a zero detect of y

   //////////////////////////////
   // Adder operand select
   //////////////////////////////
   always_comb begin
      addB   = b;
      addCin = 1'b0;
      case (op)
         opAddc: begin
            addCin = cin;
         end
         opSub: begin
            addB   = ~b;          // a + ~b + 1
            addCin = 1'b1;
         end
         default: begin
            addCin = 1'b0;
         end
      endcase
   end

   // Same sign in, other sign out
   assign addOvf = (a[dataW-1] == addB[dataW-1]) & (sum[dataW-1] != a[dataW-1]);

   carrySkipAdder #(
      .dataW     (dataW),
      .skipBlock (skipBlock)
   ) adder (
      .a        (a),
      .b        (addB),
      .carryIn  (addCin),
      .sum      (sum),
      .carryOut (addCout)
   );

   //////////////////////////////
   // Shifter
   //////////////////////////////
   assign shiftKind = shiftKindOf(op);
   assign shamt     = b[shW-1:0];    // Upper bits of b ignored

   barrelShifter #(
      .dataW (dataW)
   ) shifter (
      .data      (a),
      .shamt     (shamt),
      .shiftKind (shiftKind),
      .shifted   (shifted)
   );

   //////////////////////////////
   // Result and flags
   //////////////////////////////
   always_comb begin
      y        = '0;
      zero     = 1'b0;
      overflow = 1'b0;
      carry    = 1'b0;
      trueZero = 1'b0;
      case (op)
         // Compares leave y at zero and report through Z
         opEq:  zero = (a == b);
         opLt:  zero = ($signed(a) < $signed(b));
         opLtu: zero = (a < b);
         opGt:  zero = ($signed(a) > $signed(b));
         opGtu: zero = (a > b);

         opAdd, opAddc, opSub: begin
            y        = sum;
            overflow = addOvf;
            carry    = addCout;    // No-borrow on subtract
            trueZero = 1'b1;
         end

         opSll, opSrl, opSra: begin
            y        = shifted;
            trueZero = 1'b1;
         end

         opOr: begin
            y        = a | b;
            trueZero = 1'b1;
         end
         opXor: begin
            y        = a ^ b;
            trueZero = 1'b1;
         end
         opAnd: begin
            y        = a & b;
            trueZero = 1'b1;
         end

         // Undefined codes keep everything cleared
         default: begin
            y        = '0;
            trueZero = 1'b0;
         end
      endcase

      if (trueZero) begin
         zero = (y == '0);
      end
      negative = y[dataW-1];
   end

endmodule

//--- hdl/aluTop.sv
//////////////////////////////
// Registered ALU with operand and result stages around aluCore
//////////////////////////////
`timescale 1ns/100ps

module aluTop #(
   parameter int dataW     = 32,
   parameter int skipBlock = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             opValid,
   input  logic [dataW-1:0] opA,
   input  logic [dataW-1:0] opB,
   input  aluPkg::aluOp_e   opCode,
   input  logic             cin,
   output logic             resValid,
   output logic [dataW-1:0] result,
   output logic             flagZ,
   output logic             flagV,
   output logic             flagN,
   output logic             flagC
);
   import aluPkg::*;

   // Operand stage
   logic             s1Valid;
   logic [dataW-1:0] s1A;
   logic [dataW-1:0] s1B;
   aluOp_e           s1Op;
   logic             s1Cin;

   // Core outputs
   logic [dataW-1:0] coreY;
   logic             coreZ;
   logic             coreV;
   logic             coreN;
   logic             coreC;

   //////////////////////////////
   // Operand stage
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         s1Valid <= 1'b0;
      end else begin
         s1Valid <= opValid;
      end
   end

   always_ff @(posedge clk) begin
      if (opValid) begin    // Load only on an issued op
         s1A   <= opA;
         s1B   <= opB;
         s1Op  <= opCode;
         s1Cin <= cin;
      end
   end

   aluCore #(
      .dataW     (dataW),
      .skipBlock (skipBlock)
   ) core (
      .a        (s1A),
      .b        (s1B),
      .op       (s1Op),
      .cin      (s1Cin),
      .y        (coreY),
      .zero     (coreZ),
      .overflow (coreV),
      .negative (coreN),
      .carry    (coreC)
   );

   //////////////////////////////
   // Result stage
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         resValid <= 1'b0;
         result   <= '0;
         flagZ    <= 1'b0;
         flagV    <= 1'b0;
         flagN    <= 1'b0;
         flagC    <= 1'b0;
      end else begin
         resValid <= s1Valid;     // One-cycle strobe
         if (s1Valid) begin
            result <= coreY;
            flagZ  <= coreZ;
            flagV  <= coreV;
            flagN  <= coreN;
            flagC  <= coreC;
         end
      end
   end

endmodule

//--- verif/aluChecker.sv
//////////////////////////////
// Watches the ALU ports, predicts every result and compares it
// Reports mismatches as they occur and a summary when testDone rises
//////////////////////////////
`timescale 1ns/100ps

module aluChecker #(
   parameter int dataW = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             opValid,
   input  logic [dataW-1:0] opA,
   input  logic [dataW-1:0] opB,
   input  aluPkg::aluOp_e   opCode,
   input  logic             cin,
   input  logic             resValid,
   input  logic [dataW-1:0] result,
   input  logic             flagZ,
   input  logic             flagV,
   input  logic             flagN,
   input  logic             flagC,
   input  logic [3:0]       testId,
   input  logic             testDone,
   output int               errCount,
   output logic             reportDone
);
   import aluPkg::*;

   localparam int shW     = $clog2(dataW);
   localparam int latency = 2;   // Issue edge to the edge that sees resValid

   logic [dataW+3:0] expQ [$];   // {y, Z, V, N, C}
   int               cycQ [$];   // Issue cycle
   logic [3:0]       tagQ [$];
   logic [3:0]       opQ  [$];

   int   errs     = 0;
   int   checks   = 0;
   int   cycle    = 0;
   logic rstD1    = 1'b0;
   logic rstD2    = 1'b0;
   logic reported = 1'b0;

   assign errCount   = errs;
   assign reportDone = reported;

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic logic [dataW+3:0] refAlu(input logic [3:0] op,
                                               input logic [dataW-1:0] a,
                                               input logic [dataW-1:0] b,
                                               input logic c);
      logic [dataW-1:0] y;
      logic [dataW:0]   wide;    // Unsigned sum with carry
      logic [dataW:0]   sWide;   // Sign-extended sum or difference
      logic [shW-1:0]   amt;
      logic             z;
      logic             v;
      logic             cy;
      y   = '0;
      z   = 1'b0;
      v   = 1'b0;
      cy  = 1'b0;
      amt = b[shW-1:0];
      case (op)
         opEq:  z = (a == b);
         opLt:  z = ($signed(a) < $signed(b));
         opLtu: z = (a < b);
         opGt:  z = ($signed(a) > $signed(b));
         opGtu: z = (a > b);
         opAdd, opAddc: begin
            wide  = {1'b0, a} + {1'b0, b} + {{dataW{1'b0}}, (op == opAddc) & c};
            sWide = {a[dataW-1], a} + {b[dataW-1], b} + {{dataW{1'b0}}, (op == opAddc) & c};
            y     = wide[dataW-1:0];
            cy    = wide[dataW];
            v     = sWide[dataW] ^ sWide[dataW-1];
         end
         opSub: begin
            sWide = {a[dataW-1], a} - {b[dataW-1], b};
            y     = a - b;
            cy    = (a >= b);   // Carry set when nothing is borrowed
            v     = sWide[dataW] ^ sWide[dataW-1];
         end
         opSll: y = a << amt;
         opSrl: y = a >> amt;
         opSra: y = $signed(a) >>> amt;
         opOr:  y = a | b;
         opXor: y = a ^ b;
         opAnd: y = a & b;
         default: y = '0;
      endcase
      if (op >= opAdd && op <= opAnd) begin
         z = (y == '0);   // Plain zero detect outside compares
      end
      return {y, z, v, y[dataW-1], cy};
   endfunction

   function automatic string phaseName(input logic [3:0] id);
      case (id)
         4'd0:    return "reset";
         4'd1:    return "arith";
         4'd2:    return "compare";
         4'd3:    return "shift";
         4'd4:    return "logic";
         4'd5:    return "undefined";
         4'd6:    return "pipeline";
         default: return "unknown";
      endcase
   endfunction

   //////////////////////////////
   // Compare process
   //////////////////////////////
   always @(posedge clk) begin : compare
      logic [dataW+3:0] exp;
      logic [dataW+3:0] got;
      int               issued;
      logic [3:0]       tag;
      logic [3:0]       op;
      cycle = cycle + 1;
      rstD1 <= rst;
      rstD2 <= rstD1;
      got   = {result, flagZ, flagV, flagN, flagC};

      // Outputs read zero during reset and the cycle after
      if (rstD1 || rstD2) begin
         checks = checks + 1;
         if (resValid !== 1'b0 || got !== '0) begin
            errs = errs + 1;
            $display("ERROR %s: expected valid=0 y=%h zvnc=0000 actual valid=%b y=%h zvnc=%b",
                     phaseName(4'd0), {dataW{1'b0}}, resValid, result, got[3:0]);
         end
      end

      if (!rst && resValid === 1'b1) begin
         if (expQ.size() == 0) begin
            errs = errs + 1;
            $display("resValid went high at cycle %0d with no operation outstanding", cycle);
         end else begin
            exp    = expQ.pop_front();
            issued = cycQ.pop_front();
            tag    = tagQ.pop_front();
            op     = opQ.pop_front();
            checks = checks + 1;
            if (got !== exp) begin
               errs = errs + 1;
               $display("ERROR %s op %h: expected y=%h zvnc=%b actual y=%h zvnc=%b",
                        phaseName(tag), op, exp[dataW+3:4], exp[3:0], result, got[3:0]);
            end
            if (cycle - issued != latency) begin
               errs = errs + 1;
               $display("ERROR %s op %h: expected latency %0d actual %0d",
                        phaseName(tag), op, latency, cycle - issued);
            end
         end
      end

      if (!rst && opValid === 1'b1) begin   // Issue edge
         expQ.push_back(refAlu(opCode, opA, opB, cin));
         cycQ.push_back(cycle);
         tagQ.push_back(testId);
         opQ.push_back(opCode);
      end

      if (testDone && !reported) begin
         if (expQ.size() != 0) begin
            errs = errs + 1;
            $display("%0d results never came out of the ALU", expQ.size());
         end
         $display("Checker summary: %0d errors in %0d checks", errs, checks);
         reported <= 1'b1;
      end
   end

endmodule

//--- verif/aluTb.sv
//////////////////////////////
// Testbench top for the registered ALU
// Directed and random operations, checked by aluChecker
//////////////////////////////
`timescale 1ns/100ps

module aluTb;
   import aluPkg::*;

   localparam int dataW       = 32;
   localparam int skipBlock   = 4;
   localparam int shW         = $clog2(dataW);
   localparam int clkPeriod   = 40;
   localparam int resetCycles = 4;

   // Operations per phase
   localparam int numDirected  = 46;
   localparam int numRandArith = 60;
   localparam int numRandCmp   = 40;
   localparam int numRandShift = 30;
   localparam int numRandLogic = 30;
   localparam int numPipe      = 120;
   localparam int maxGap       = 2;
   localparam int numOps       = numDirected + numRandArith + numRandCmp
                               + numRandShift + numRandLogic + numPipe;
   localparam int watchdogNs   = (numOps * (maxGap + 1) + resetCycles + 100) * clkPeriod;

   logic             clk = 1'b0;
   logic             rst;
   logic             opValid;
   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;
   aluOp_e           opCode;
   logic             cin;
   logic             resValid;
   logic [dataW-1:0] result;
   logic             flagZ;
   logic             flagV;
   logic             flagN;
   logic             flagC;

   logic [3:0]       testId;     // Phase tag seen by the checker
   logic [3:0]       curTest;
   logic             testDone;
   int               errCount;
   logic             reportDone;
   int               seed = 32'h3f33b0c9;

   always #(clkPeriod / 2) clk = ~clk;

   aluTop #(
      .dataW     (dataW),
      .skipBlock (skipBlock)
   ) uut (
      .clk      (clk),
      .rst      (rst),
      .opValid  (opValid),
      .opA      (opA),
      .opB      (opB),
      .opCode   (opCode),
      .cin      (cin),
      .resValid (resValid),
      .result   (result),
      .flagZ    (flagZ),
      .flagV    (flagV),
      .flagN    (flagN),
      .flagC    (flagC)
   );

   aluChecker #(
      .dataW (dataW)
   ) chk (
      .clk        (clk),
      .rst        (rst),
      .opValid    (opValid),
      .opA        (opA),
      .opB        (opB),
      .opCode     (opCode),
      .cin        (cin),
      .resValid   (resValid),
      .result     (result),
      .flagZ      (flagZ),
      .flagV      (flagV),
      .flagN      (flagN),
      .flagC      (flagC),
      .testId     (testId),
      .testDone   (testDone),
      .errCount   (errCount),
      .reportDone (reportDone)
   );

   // Valid stays high until the next idle cycle
   task automatic issueOp(input logic [3:0] code, input logic [dataW-1:0] a,
                          input logic [dataW-1:0] b, input logic c);
      @(posedge clk);
      opValid <= 1'b1;
      opCode  <= aluOp_e'(code);
      opA     <= a;
      opB     <= b;
      cin     <= c;
      testId  <= curTest;
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge clk);
         opValid <= 1'b0;
      end
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial begin : stimulus
      logic [dataW-1:0] ra;
      logic [dataW-1:0] rb;
      logic [dataW-1:0] rc;
      logic [shW-1:0]   amt;
      rst      = 1'b1;
      opValid  = 1'b0;
      opA      = '0;
      opB      = '0;
      opCode   = opAdd;
      cin      = 1'b0;
      testId   = 4'd0;
      curTest  = 4'd0;
      testDone = 1'b0;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      idleCycles(2);   // Quiet cycles for the reset check

      curTest = 4'd1;
      issueOp(opAdd, 32'h7fffffff, 32'h00000001, 1'b0);   // Signed overflow
      issueOp(opSub, 32'h80000000, 32'h00000001, 1'b0);
      issueOp(opSub, 32'h00000000, 32'h00000001, 1'b0);   // Borrow
      issueOp(opAddc, 32'hffffffff, 32'h00000001, 1'b1);
      issueOp(opAdd, 32'hffffffff, 32'h00000001, 1'b1);   // cin ignored
      issueOp(opAddc, 32'h7fffffff, 32'h00000000, 1'b1);
      for (int i = 0; i < numRandArith; i++) begin
         ra = $random(seed);
         rb = $random(seed);
         rc = $random(seed);
         issueOp((rc[1:0] == 2'd3) ? 4'd7 : 4'd5 + {2'b00, rc[1:0]}, ra, rb, rc[2]);
      end

      curTest = 4'd2;
      for (int k = 0; k < 5; k++) begin
         ra = $random(seed);
         issueOp(4'(k), ra, ra, 1'b0);
         issueOp(4'(k), 32'h00000005, 32'h80000005, 1'b0);   // Sign bit only
         issueOp(4'(k), 32'h80000005, 32'h00000005, 1'b0);
      end
      for (int i = 0; i < numRandCmp; i++) begin
         ra = $random(seed);
         rb = $random(seed);
         rc = $random(seed);
         issueOp({1'b0, (rc[2:0] > 3'd4) ? {1'b0, rc[1:0]} : rc[2:0]}, ra,
                 rc[4] ? ra : rb, 1'b0);
      end

      curTest = 4'd3;
      for (int k = 0; k < 3; k++) begin
         for (int i = 0; i < 3; i++) begin
            rb  = $random(seed);
            amt = (i == 0) ? 5'd0 : (i == 1) ? 5'd1 : 5'd31;
            issueOp(4'(8 + k), 32'h80000001, {rb[dataW-1:shW], amt}, 1'b0);
            issueOp(4'(8 + k), 32'h7ff00ff1, {rb[dataW-1:shW], amt}, 1'b0);
         end
      end
      for (int i = 0; i < numRandShift; i++) begin
         ra = $random(seed);
         rb = $random(seed);
         rc = $random(seed);
         issueOp(4'd8 + {2'b00, (rc[1:0] == 2'd3) ? 2'd2 : rc[1:0]}, ra, rb, rc[2]);
      end

      curTest = 4'd4;
      ra = $random(seed);
      issueOp(opAnd, ra, ~ra, 1'b0);   // Zero results
      issueOp(opOr, 32'h0, 32'h0, 1'b0);
      issueOp(opXor, ra, ra, 1'b0);
      for (int i = 0; i < numRandLogic; i++) begin
         ra = $random(seed);
         rb = $random(seed);
         rc = $random(seed);
         issueOp(4'd11 + {2'b00, (rc[1:0] == 2'd3) ? 2'd2 : rc[1:0]}, ra, rb, rc[2]);
      end

      curTest = 4'd5;
      for (int u = 0; u < 4; u++) begin
         ra = $random(seed);
         rb = $random(seed);
         issueOp((u < 2) ? 4'd14 : 4'd15, ra, rb, 1'b1);
      end

      // Back to back with random gaps, any opcode
      curTest = 4'd6;
      for (int i = 0; i < numPipe; i++) begin
         ra = $random(seed);
         rb = $random(seed);
         rc = $random(seed);
         issueOp(rc[3:0], ra, rb, rc[4]);
         if (rc[7:5] == 3'd0) begin
            idleCycles(rc[8] ? 2 : 1);
         end
      end

      idleCycles(4);   // Drain the pipeline
      @(posedge clk);
      testDone <= 1'b1;
      wait (reportDone);
      if (errCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   //////////////////////////////
   // Watchdog
   //////////////////////////////
   initial begin
      #(watchdogNs);
      $display("Timeout: the run did not finish within %0d ns", watchdogNs);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- filelist.f
common/aluPkg.sv
alu/carrySkipAdder.sv
alu/barrelShifter.sv
alu/aluCore.sv
hdl/aluTop.sv
verif/aluChecker.sv
verif/aluTb.sv

//--- run.sh
#!/bin/sh
# Builds the ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module aluTb -o aluSim \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/aluSim > sim.log 2>&1 \
   || echo "Simulator exited with an error status" >> sim.log

cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }

echo "Simulation passed"
exit 0
